// File: design/fetch_consts.svh
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// bit positions in the control word
`define CTRL_START_BIT       0
`define CTRL_SOFT_RESET_BIT  1

// byte step between consecutive fetch addresses
`define PC_STEP              32'd4

// consecutive req cycles before the grant
`define IMEM_GRANT_WAIT      3

// clock edges from grant to rvalid
// keep at least 1 for the BRAM read latency
`define IMEM_RVALID_DELAY    2

// cycles of done before stop is raised
`define STOP_HOLD_CYCLES     30

`endif

// File: design/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // data or address word
    typedef logic [31:0] word_t;

    // cycle and hold counters
    typedef logic [31:0] count_t;

endpackage

`default_nettype wire

// File: design/imem_if.sv
`default_nettype none

// fetch request path between the sequencer and the bridge
interface imem_if;
    import fetch_pkg::*;

    logic  req;
    word_t addr;
    logic  gnt;
    logic  rvalid;
    word_t rdata;

    // one request outstanding, addr held until gnt
    modport requester (
        output req,
        output addr,
        input  gnt,
        input  rvalid,
        input  rdata
    );

    modport responder (
        input  req,
        input  addr,
        output gnt,
        output rvalid,
        output rdata
    );

endinterface

`default_nettype wire

// File: design/run_control.sv
`default_nettype none

`include "fetch_consts.svh"

module run_control (
    input  wire                   clk,
    input  wire                   reset,
    input  wire fetch_pkg::word_t ctrl_i,
    input  wire                   done_i,
    output logic                  start_o,
    output logic                  soft_reset_o,
    output logic                  enable_o,
    output logic                  stop_o,
    output fetch_pkg::count_t     cycle_count_o
);
    import fetch_pkg::*;

    localparam count_t HOLD_LAST = count_t'(`STOP_HOLD_CYCLES - 1);

    // previous value of the two control bits
    logic   start_bit_q;
    logic   soft_bit_q;
    logic   start_q;
    logic   soft_reset_q;
    logic   enable_q;
    logic   stop_q;
    logic   clear;
    count_t cycle_cnt_q;
    count_t hold_cnt_q;

    assign start_o       = start_q;
    assign soft_reset_o  = soft_reset_q;
    assign enable_o      = enable_q;
    assign stop_o        = stop_q;
    assign cycle_count_o = cycle_cnt_q;

    // soft reset clears the run state like reset
    assign clear = reset | soft_reset_q;

    // rising-edge strobes, one cycle wide
    always_ff @(posedge clk) begin
        if (reset) begin
            start_bit_q  <= 1'b0;
            soft_bit_q   <= 1'b0;
            start_q      <= 1'b0;
            soft_reset_q <= 1'b0;
        end else begin
            start_bit_q  <= ctrl_i[`CTRL_START_BIT];
            soft_bit_q   <= ctrl_i[`CTRL_SOFT_RESET_BIT];
            start_q      <= ctrl_i[`CTRL_START_BIT] & ~start_bit_q;
            soft_reset_q <= ctrl_i[`CTRL_SOFT_RESET_BIT] & ~soft_bit_q;
        end
    end

    // enable, cycle count and sticky stop
    always_ff @(posedge clk) begin
        if (clear) begin
            enable_q    <= 1'b0;
            stop_q      <= 1'b0;
            cycle_cnt_q <= '0;
            hold_cnt_q  <= '0;
        end else if (start_q && !stop_q) begin
            // new run starts counting from zero
            enable_q    <= 1'b1;
            cycle_cnt_q <= '0;
            hold_cnt_q  <= '0;
        end else if (!stop_q) begin
            if (enable_q) begin
                cycle_cnt_q <= cycle_cnt_q + 32'd1;
            end
            if (done_i) begin
                hold_cnt_q <= hold_cnt_q + 32'd1;
                // success held long enough
                if (hold_cnt_q == HOLD_LAST) begin
                    stop_q   <= 1'b1;
                    enable_q <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/fetch_sequencer.sv
`default_nettype none

`include "fetch_consts.svh"

module fetch_sequencer (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   start_i,
    input  wire                   soft_reset_i,
    input  wire                   enable_i,
    input  wire fetch_pkg::word_t initial_pc_i,
    input  wire fetch_pkg::word_t success_code_i,
    output logic                  done_o,
    imem_if.requester             mem
);
    import fetch_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_WAIT
    } state_t;

    state_t state_q;
    word_t  pc_q;
    logic   req_q;
    logic   done_q;

    assign mem.req  = req_q;
    assign mem.addr = pc_q;
    assign done_o   = done_q;

    always_ff @(posedge clk) begin
        if (reset || soft_reset_i) begin
            state_q <= S_IDLE;
            req_q   <= 1'b0;
            done_q  <= 1'b0;
        end else if (start_i) begin
            // fresh run from the initial pc
            state_q <= S_IDLE;
            pc_q    <= initial_pc_i;
            req_q   <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            unique case (state_q)
                S_IDLE: begin
                    if (enable_i && !done_q) begin
                        req_q   <= 1'b1;
                        state_q <= S_REQ;
                    end
                end
                S_REQ: begin
                    // hold req and addr until granted
                    if (mem.gnt) begin
                        req_q   <= 1'b0;
                        state_q <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (mem.rvalid) begin
                        state_q <= S_IDLE;
                        if (mem.rdata == success_code_i) begin
                            done_q <= 1'b1;
                        end else begin
                            pc_q <= pc_q + `PC_STEP;
                        end
                    end
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/imem_bridge.sv
`default_nettype none

`include "fetch_consts.svh"

module imem_bridge (
    input  wire                   clk,
    input  wire                   reset,
    imem_if.responder             bus,
    output logic                  mem_en_o,
    output fetch_pkg::word_t      mem_addr_o,
    input  wire fetch_pkg::word_t mem_rdata_i
);

    localparam int GRANT_LAST = `IMEM_GRANT_WAIT - 1;
    localparam int CNT_W      = $clog2(`IMEM_GRANT_WAIT) + 1;
    localparam int DELAY      = `IMEM_RVALID_DELAY;

    // consecutive cycles of req seen so far
    logic [CNT_W-1:0] wait_cnt_q;
    logic [DELAY-1:0] valid_sr_q;
    logic             grant;

    // grant on the last cycle of the wait
    assign grant = bus.req && (wait_cnt_q == CNT_W'(GRANT_LAST));

    assign bus.gnt = grant;

    // BRAM read issued in the grant cycle
    assign mem_en_o   = grant;
    assign mem_addr_o = bus.addr;

    assign bus.rvalid = valid_sr_q[DELAY-1];
    // BRAM holds its output between reads
    assign bus.rdata  = mem_rdata_i;

    always_ff @(posedge clk) begin
        if (reset || !bus.req || grant) begin
            wait_cnt_q <= '0;
        end else begin
            wait_cnt_q <= wait_cnt_q + 1'b1;
        end
    end

    // delay line from grant to rvalid
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_sr_q <= '0;
        end else begin
            valid_sr_q[0] <= grant;
            for (int i = 1; i < DELAY; i++) begin
                valid_sr_q[i] <= valid_sr_q[i-1];
            end
        end
    end

endmodule

`default_nettype wire

// File: design/fetch_harness_top.sv
`default_nettype none

module fetch_harness_top (
    input  wire                    clk,
    input  wire                    reset,

    // control and run parameters
    input  wire fetch_pkg::word_t  gpio_ctrl_i,
    input  wire fetch_pkg::word_t  initial_pc_i,
    input  wire fetch_pkg::word_t  success_code_i,

    output wire                    stop_sim_o,
    output wire fetch_pkg::count_t cycle_count_o,

    // instruction BRAM port
    output wire                    ins_mem_enb_o,
    output wire fetch_pkg::word_t  ins_mem_addrb_o,
    input  wire fetch_pkg::word_t  ins_mem_doutb_i
);

    logic start;
    logic soft_reset;
    logic enable;
    logic done;

    imem_if imem_bus ();

    run_control u_run_control (
        .clk           (clk),
        .reset         (reset),
        .ctrl_i        (gpio_ctrl_i),
        .done_i        (done),
        .start_o       (start),
        .soft_reset_o  (soft_reset),
        .enable_o      (enable),
        .stop_o        (stop_sim_o),
        .cycle_count_o (cycle_count_o)
    );

    fetch_sequencer u_fetch_sequencer (
        .clk            (clk),
        .reset          (reset),
        .start_i        (start),
        .soft_reset_i   (soft_reset),
        .enable_i       (enable),
        .initial_pc_i   (initial_pc_i),
        .success_code_i (success_code_i),
        .done_o         (done),
        .mem            (imem_bus.requester)
    );

    imem_bridge u_imem_bridge (
        .clk         (clk),
        .reset       (reset),
        .bus         (imem_bus.responder),
        .mem_en_o    (ins_mem_enb_o),
        .mem_addr_o  (ins_mem_addrb_o),
        .mem_rdata_i (ins_mem_doutb_i)
    );

endmodule

`default_nettype wire

// File: sim/tb_checker.sv
`default_nettype none

`include "fetch_consts.svh"

module tb_checker (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    mem_en_i,
    input  wire fetch_pkg::word_t  mem_addr_i,
    input  wire                    stop_i,
    input  wire fetch_pkg::count_t cycle_count_i,
    input  wire fetch_pkg::word_t  exp_pc_i,
    input  wire fetch_pkg::word_t  exp_k_i,
    input  wire [2:0]              test_id_i,
    input  wire                    run_start_i,
    input  wire [2:0]              report_i,
    output int                     errors_o,
    output int                     tests_done_o,
    output int                     tests_failed_o
);
    import fetch_pkg::*;

    int     err_cnt [1:5];
    int     fetch_n;
    int     since_en;
    int     run_cyc;
    logic   running;
    logic   prev_stop;
    count_t prev_count;
    word_t  exp_addr;

    function automatic string test_name(input int t);
        case (t)
            1: return "idle_after_reset";
            2: return "fetch_order";
            3: return "success_stop";
            4: return "cycle_counter";
            default: return "soft_reset_restart";
        endcase
    endfunction

    // during the restart run every error belongs to test 5
    task automatic value_error(
        input int    t,
        input string what,
        input word_t exp,
        input word_t act
    );
        int ti;
        ti = (test_id_i == 3'd5) ? 5 : t;
        err_cnt[ti]++;
        errors_o++;
        $display("error %s (%s): expected %h, actual %h", test_name(ti), what, exp, act);
    endtask

    initial begin
        errors_o       = 0;
        tests_done_o   = 0;
        tests_failed_o = 0;
        for (int i = 1; i <= 5; i++) begin
            err_cnt[i] = 0;
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            fetch_n    = 0;
            since_en   = 0;
            run_cyc    = 0;
            running    = 1'b0;
            prev_stop  = 1'b0;
            prev_count = '0;
        end else begin
            if (run_start_i) begin
                fetch_n = 0;
                run_cyc = 0;
                running = 1'b1;
            end else begin
                run_cyc++;
            end
            if (test_id_i == 3'd1) begin
                // nothing moves before the first start
                if (mem_en_i || stop_i || cycle_count_i != '0) begin
                    value_error(1, "enable, stop, count", '0,
                                {mem_en_i, stop_i, 14'd0, cycle_count_i[15:0]});
                end
            end else if (mem_en_i) begin
                if (stop_i) begin
                    value_error(3, "BRAM enable after stop", 0, 1);
                end else if (fetch_n > int'(exp_k_i)) begin
                    value_error(2, "fetch count", exp_k_i + 1, word_t'(fetch_n + 1));
                end else begin
                    exp_addr = exp_pc_i + word_t'(fetch_n) * `PC_STEP;
                    if (mem_addr_i !== exp_addr) begin
                        value_error(2, "fetch address", exp_addr, mem_addr_i);
                    end
                end
                fetch_n++;
            end
            since_en = mem_en_i ? 0 : since_en + 1;
            // stop only after the success word and the full hold
            if (stop_i && !prev_stop) begin
                if (fetch_n != int'(exp_k_i) + 1) begin
                    value_error(2, "fetches before stop", exp_k_i + 1, word_t'(fetch_n));
                end
                if (since_en < `STOP_HOLD_CYCLES) begin
                    value_error(3, "idle cycles before stop", `STOP_HOLD_CYCLES,
                                word_t'(since_en));
                end
            end
            // counter frozen after stop and cleared by soft reset
            if (prev_stop && stop_i) begin
                if (cycle_count_i != prev_count) begin
                    value_error(4, "count after stop", prev_count, cycle_count_i);
                end
            end else if (prev_stop) begin
                if (cycle_count_i != '0) begin
                    value_error(5, "count after soft reset", '0, cycle_count_i);
                end
            end else if (running && run_cyc >= 3) begin
                // +1 per cycle once enable is up, up to the stop edge
                if (cycle_count_i != prev_count + 1) begin
                    value_error(4, "count step", prev_count + 1, cycle_count_i);
                end
            end
            if (stop_i) begin
                running = 1'b0;
            end
            if (report_i != 3'd0) begin
                tests_done_o++;
                if (err_cnt[report_i] == 0) begin
                    $display("test %s: ok", test_name(report_i));
                end else begin
                    tests_failed_o++;
                    $display("test %s: failed, %0d errors", test_name(report_i),
                             err_cnt[report_i]);
                end
            end
            prev_stop  = stop_i;
            prev_count = cycle_count_i;
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_top.sv
`default_nettype none

`include "fetch_consts.svh"

module tb_top;
    import fetch_pkg::*;

    localparam int WAIT_LIMIT = 5000;

    logic   clk;
    logic   reset;
    word_t  gpio_ctrl;
    word_t  initial_pc;
    word_t  success_code;
    word_t  mem_dout;
    logic   mem_en;
    word_t  mem_addr;
    logic   stop_sim;
    count_t cycle_count;

    // program image, one word per BRAM row
    word_t  image [0:255];
    integer seed;
    logic   timed_out;

    // current run as seen by the checker
    word_t      exp_pc;
    word_t      exp_k;
    logic [2:0] test_id;
    logic [2:0] report_id;
    logic       run_start;
    int         errors;
    int         tests_done;
    int         tests_failed;

    fetch_harness_top dut_i (
        .clk             (clk),
        .reset           (reset),
        .gpio_ctrl_i     (gpio_ctrl),
        .initial_pc_i    (initial_pc),
        .success_code_i  (success_code),
        .stop_sim_o      (stop_sim),
        .cycle_count_o   (cycle_count),
        .ins_mem_enb_o   (mem_en),
        .ins_mem_addrb_o (mem_addr),
        .ins_mem_doutb_i (mem_dout)
    );

    tb_checker checker_i (
        .clk            (clk),
        .reset          (reset),
        .mem_en_i       (mem_en),
        .mem_addr_i     (mem_addr),
        .stop_i         (stop_sim),
        .cycle_count_i  (cycle_count),
        .exp_pc_i       (exp_pc),
        .exp_k_i        (exp_k),
        .test_id_i      (test_id),
        .run_start_i    (run_start),
        .report_i       (report_id),
        .errors_o       (errors),
        .tests_done_o   (tests_done),
        .tests_failed_o (tests_failed)
    );

    always #20 clk = ~clk;

    // BRAM model, one cycle read latency, output held between reads
    always @(posedge clk) begin
        if (mem_en) begin
            mem_dout <= image[mem_addr[9:2]];
        end
    end

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // random words, success code only at fetch k from pc
    task automatic load_program(input word_t pc, input int k);
        word_t w;
        for (int i = 0; i < 256; i++) begin
            w = $random(seed);
            if (w == success_code) begin
                w = ~w;
            end
            image[i] = w;
        end
        image[(int'(pc[9:2]) + k) % 256] = success_code;
    endtask

    task automatic report_test(input logic [2:0] id);
        @(posedge clk);
        report_id <= id;
        @(posedge clk);
        report_id <= 3'd0;
    endtask

    task automatic wait_stop(input logic level, input string what);
        int n;
        n = 0;
        while (stop_sim !== level && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (stop_sim !== level) begin
            $display("timeout: stop_sim_o did not %s within %0d cycles", what, WAIT_LIMIT);
            timed_out = 1'b1;
        end
    endtask

    task automatic run_program(input logic [2:0] id);
        word_t pc;
        int    k;
        pc = word_t'($random(seed)) & ~32'h3;
        k  = int'($unsigned($random(seed)) % 256);
        load_program(pc, k);
        @(posedge clk);
        initial_pc <= pc;
        exp_pc     <= pc;
        exp_k      <= word_t'(k);
        test_id    <= id;
        run_start  <= 1'b1;
        gpio_ctrl[`CTRL_START_BIT] <= 1'b1;
        @(posedge clk);
        run_start <= 1'b0;
        gpio_ctrl[`CTRL_START_BIT] <= 1'b0;
        wait_stop(1'b1, "rise after the success word");
        if (!timed_out) begin
            // checker watches for stray fetches while stopped
            idle_cycles(100);
        end
    endtask

    task automatic run_tests();
        idle_cycles(50);
        report_test(3'd1);
        run_program(3'd2);
        if (!timed_out) begin
            report_test(3'd2);
            report_test(3'd3);
            report_test(3'd4);
            @(posedge clk);
            test_id <= 3'd5;
            gpio_ctrl[`CTRL_SOFT_RESET_BIT] <= 1'b1;
            wait_stop(1'b0, "fall after soft reset");
        end
        if (!timed_out) begin
            @(posedge clk);
            gpio_ctrl[`CTRL_SOFT_RESET_BIT] <= 1'b0;
            run_program(3'd5);
        end
        if (!timed_out) begin
            report_test(3'd5);
        end
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        gpio_ctrl    = '0;
        initial_pc   = '0;
        mem_dout     = '0;
        exp_pc       = '0;
        exp_k        = '0;
        test_id      = 3'd1;
        report_id    = 3'd0;
        run_start    = 1'b0;
        timed_out    = 1'b0;
        seed         = 32'hdc08e182;
        success_code = $random(seed);
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        run_tests();
        idle_cycles(2);
        $display("tests %0d, failed %0d, errors %0d, timeout %0d",
                 tests_done, tests_failed, errors, timed_out);
        if (timed_out || errors != 0 || tests_failed != 0 || tests_done != 5) begin
            $display("=== FAIL ===");
        end else begin
            $display("=== PASS ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+design
design/fetch_pkg.sv
design/imem_if.sv
design/run_control.sv
design/fetch_sequencer.sv
design/imem_bridge.sv
design/fetch_harness_top.sv
sim/tb_checker.sv
sim/tb_top.sv
